/* compile.f */
logic/shell_pkg.sv
logic/status_decode.sv
logic/sd_router.sv
logic/tape_path.sv
logic/shell_top.sv
tb/tb_shell_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -Wno-fatal -j 0
TOP       = tb_shell_top
FILELIST  = compile.f
SOURCES   = $(shell cat $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

/* tb/tb_shell_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_shell_top
   import shell_pkg::*;
();

   localparam int clk_period   = 10;
   localparam int act_timeout  = 64;
   localparam int reset_cycles = 16;
   // Sum of the test lengths in cycles
   localparam int test_cycles  = 40 + 44 + 30 + (2 * (act_timeout + 26) + 20) + 60 + 30;
   localparam int watchdog_cycles = reset_cycles + test_cycles + 100;

   logic                     clock_bus, rst_n;
   logic [status_w-1:0]      status;
   logic [5:0]               img_mounted;
   logic [63:0]              img_size;
   logic [hdmi_dim_w-1:0]    hdmi_width, hdmi_height;
   logic                     forced_scandoubler, ioctl_download;
   logic [ioctl_index_w-1:0] ioctl_index;
   logic                     fdc_enable, ocm_enable, rom_a_hide, rom_b_hide, sram_present;
   logic                     board_reset, tape_motor_on, cas_dout, adc_tape, adc_tape_act;
   logic                     sd_spi_clk, sd_spi_mosi, sd_miso_pin, vsd_miso;
   ddr3_addr_t               ddr3_addr_dl, ddr3_addr_cas, ddr3_addr;
   logic                     ddr3_rd_dl, ddr3_req_dl, ddr3_rd_cas, ddr3_rd;
   logic                     core_reset, hard_reset, scandoubler, hq2x;
   logic [15:0]              menu_mask;
   logic [11:0]              video_arx, video_ary, crop_size;
   logic [1:0]               vga_sl, led_disk;
   logic                     sd_cs, sd_sck, sd_mosi, sd_miso, led_user;
   logic                     tape_in, tape_play, tape_rewind;

   int          errors;
   int          prop_errors;
   int          checks;
   int          test_start;
   int          last_crop;
   logic [31:0] lfsr_state;

   shell_top #(
      .act_timeout (act_timeout)
   ) u_dut (.*);

   // ==========================================================
   // Clock, watchdog and cycle-level properties
   // ==========================================================

   initial begin
      clock_bus = 1'b0;
      forever #(clk_period / 2) clock_bus = ~clock_bus;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
      $display("TEST FAILED");
      $finish;
   end

   assert property (@(posedge clock_bus) led_disk[1] == 1'b1)
      else begin
         $display("[ERROR] %0t ns: led_disk[1] expected 1, got %0b", $time, led_disk[1]);
         prop_errors++;
      end

   // ==========================================================
   // Random numbers and checking
   // ==========================================================

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      // Taps 32 22 2 1
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic rand_bit();
      lfsr_state = lfsr_step(lfsr_state);
      return lfsr_state[0];
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[62:0], rand_bit()};
      end
      return r;
   endfunction

   task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      assert (act === exp)
         else begin
            $display("[ERROR] %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
         end
   endtask

   task automatic report_test(input string name);
      if (errors == test_start) begin
         $display("test %s: passed", name);
      end else begin
         $display("test %s: %0d errors", name, errors - test_start);
      end
   endtask

   // ==========================================================
   // Tests
   // ==========================================================

   task automatic resets_and_mask();
      logic        hr;
      logic        cr;
      logic [15:0] mask;
      for (int i = 0; i < 40; i++) begin
         @(posedge clock_bus);
         status       <= rand_bits(64);
         img_mounted  <= 6'(rand_bits(6));
         board_reset  <= rand_bit();
         fdc_enable   <= rand_bit();
         ocm_enable   <= rand_bit();
         rom_a_hide   <= rand_bit();
         rom_b_hide   <= rand_bit();
         sram_present <= rand_bit();
         @(negedge clock_bus);
         hr = board_reset | status[st_reset];
         cr = hr | status[st_detach] | status[st_reset_close]
            | (status[st_reset_mount] & img_mounted[vsd_slot] & fdc_enable);
         mask    = '0;
         mask[0] = fdc_enable;
         mask[1] = rom_a_hide | ocm_enable;
         mask[2] = rom_b_hide | ocm_enable;
         mask[3] = ocm_enable;
         mask[6] = ~sram_present;
         mask[7] = status[st_tape_src];
         expect_eq("hard_reset", hr, hard_reset);
         expect_eq("core_reset", cr, core_reset);
         expect_eq("menu_mask", mask, menu_mask);
      end
      @(posedge clock_bus);
      img_mounted <= '0;
      board_reset <= 1'b0;
   endtask

   // Registered crop checked before and after its one-cycle delay
   task automatic crop_case(input int w, input int h, input logic fsd, input logic [2:0] scale,
                            input int exp);
      logic [status_w-1:0] st;
      st = '0;
      st[st_scale_lo +: 3] = scale;
      @(posedge clock_bus);
      hdmi_width         <= 12'(w);
      hdmi_height        <= 12'(h);
      forced_scandoubler <= fsd;
      status             <= st;
      @(negedge clock_bus);
      expect_eq("crop_size", last_crop, crop_size);
      @(posedge clock_bus);
      @(negedge clock_bus);
      expect_eq("crop_size", exp, crop_size);
      last_crop = exp;
   endtask

   task automatic video_decode();
      logic [status_w-1:0] st;
      logic                fsd;
      for (int a = 0; a < 4; a++) begin
         for (int s = 0; s < 8; s++) begin
            st = '0;
            st[st_aspect_lo +: 2] = 2'(a);
            st[st_scale_lo +: 3]  = 3'(s);
            fsd = rand_bit();
            @(posedge clock_bus);
            status             <= st;
            forced_scandoubler <= fsd;
            @(negedge clock_bus);
            expect_eq("video_arx", (a == 0) ? 4 : a - 1, video_arx);
            expect_eq("video_ary", (a == 0) ? 3 : 0, video_ary);
            expect_eq("vga_sl", (s == 0) ? 0 : (s - 1) % 4, vga_sl);
            expect_eq("scandoubler", fsd | (s != 0), scandoubler);
            expect_eq("hq2x", s == 1, hq2x);
         end
      end
      crop_case(1920, 1080, 1'b0, 3'd0, 216);
      crop_case(1920, 1080, 1'b1, 3'd0, 0);
      crop_case(1920, 1080, 1'b0, 3'd0, 216);
      crop_case(1920, 1080, 1'b0, 3'd2, 0);
      crop_case(1280, 1080, 1'b0, 3'd0, 0);
      crop_case(1920, 720, 1'b0, 3'd0, 0);
   endtask

   task automatic check_sd(input logic sel);
      expect_eq("sd_cs", sel, sd_cs);
      expect_eq("sd_sck", sel ? 1'b0 : sd_spi_clk, sd_sck);
      expect_eq("sd_mosi", sel ? 1'b0 : sd_spi_mosi, sd_mosi);
      expect_eq("sd_miso", sel ? vsd_miso : sd_miso_pin, sd_miso);
   endtask

   task automatic drive_sd_pins(input logic sel, input int n);
      repeat (n) begin
         @(posedge clock_bus);
         sd_spi_clk  <= rand_bit();
         sd_spi_mosi <= rand_bit();
         sd_miso_pin <= rand_bit();
         vsd_miso    <= rand_bit();
         @(negedge clock_bus);
         check_sd(sel);
      end
   endtask

   // One-cycle pulse on the virtual SD mount slot
   task automatic mount_image(input logic [63:0] size);
      @(posedge clock_bus);
      img_mounted <= 6'(1 << vsd_slot);
      img_size    <= size;
      @(posedge clock_bus);
      img_mounted <= '0;
   endtask

   task automatic sd_routing();
      drive_sd_pins(1'b0, 8);
      mount_image(rand_bits(64) | 64'd1);
      @(negedge clock_bus);
      check_sd(1'b1);
      drive_sd_pins(1'b1, 8);
      mount_image(64'd0);
      @(negedge clock_bus);
      check_sd(1'b0);
      drive_sd_pins(1'b0, 8);
   endtask

   task automatic check_light(input logic on, input logic sel);
      expect_eq("led_user", on & sel, led_user);
      expect_eq("led_disk[0]", on & ~sel, led_disk[0]);
   endtask

   // Toggle burst followed by the quiet countdown until the light falls
   task automatic run_light(input logic sel);
      @(posedge clock_bus);
      sd_spi_mosi <= ~sd_spi_mosi;
      @(negedge clock_bus);
      check_light(1'b0, sel);
      repeat (20) begin
         @(posedge clock_bus);
         sd_spi_mosi <= rand_bit();
         @(negedge clock_bus);
         check_light(1'b1, sel);
      end
      @(posedge clock_bus);
      sd_spi_mosi <= ~sd_spi_mosi;
      repeat (act_timeout + 1) begin
         @(posedge clock_bus);
         @(negedge clock_bus);
         check_light(1'b1, sel);
      end
      @(posedge clock_bus);
      @(negedge clock_bus);
      check_light(1'b0, sel);
   endtask

   task automatic activity_light();
      @(posedge clock_bus);
      {sd_spi_clk, sd_spi_mosi, sd_miso_pin, vsd_miso} <= '0;
      rst_n <= 1'b0;
      repeat (2) @(posedge clock_bus);
      rst_n <= 1'b1;
      repeat (10) begin
         @(negedge clock_bus);
         check_light(1'b0, 1'b0);
      end
      run_light(1'b0);
      mount_image(64'h400);
      run_light(1'b1);
      mount_image(64'd0);
   endtask

   task automatic run_download(input logic [15:0] idx, input int n, input logic is_cas);
      @(posedge clock_bus);
      ioctl_index    <= idx;
      ioctl_download <= 1'b1;
      repeat (n) begin
         @(negedge clock_bus);
         expect_eq("tape_rewind", is_cas, tape_rewind);
         @(posedge clock_bus);
      end
      ioctl_download <= 1'b0;
      @(negedge clock_bus);
      expect_eq("tape_rewind", 1'b0, tape_rewind);
      @(posedge clock_bus);
      @(negedge clock_bus);
   endtask

   task automatic cassette_path();
      logic [status_w-1:0] st;
      @(posedge clock_bus);
      status        <= '0;
      tape_motor_on <= 1'b0;
      run_download(16'h0003, 4, 1'b0);
      expect_eq("tape_play", 1'b0, tape_play);
      run_download(16'(cas_index), 6, 1'b1);
      expect_eq("tape_play", 1'b1, tape_play);
      repeat (6) begin
         @(posedge clock_bus);
         tape_motor_on <= rand_bit();
         @(negedge clock_bus);
         expect_eq("tape_play", !tape_motor_on, tape_play);
      end
      // Rewind from board reset, detach and status rewind
      for (int i = 0; i < 4; i++) begin
         st = '0;
         st[st_detach]      = i == 1;
         st[st_tape_rewind] = i == 2;
         @(posedge clock_bus);
         board_reset <= i == 0;
         status      <= st;
         @(negedge clock_bus);
         expect_eq("tape_rewind", i != 3, tape_rewind);
      end
      for (int i = 0; i < 20; i++) begin
         st = '0;
         st[st_tape_src] = rand_bit();
         @(posedge clock_bus);
         status       <= st;
         cas_dout     <= rand_bit();
         adc_tape     <= rand_bit();
         adc_tape_act <= rand_bit();
         @(negedge clock_bus);
         expect_eq("tape_in", status[st_tape_src] ? adc_tape & adc_tape_act : cas_dout, tape_in);
      end
   endtask

   task automatic ddr3_sharing();
      for (int i = 0; i < 30; i++) begin
         @(posedge clock_bus);
         ddr3_addr_dl  <= ddr3_addr_t'(rand_bits(ddr3_addr_w));
         ddr3_addr_cas <= ddr3_addr_t'(rand_bits(ddr3_addr_w));
         ddr3_rd_dl    <= rand_bit();
         ddr3_rd_cas   <= rand_bit();
         ddr3_req_dl   <= rand_bit();
         @(negedge clock_bus);
         expect_eq("ddr3_addr", ddr3_req_dl ? ddr3_addr_dl : ddr3_addr_cas, ddr3_addr);
         expect_eq("ddr3_rd", ddr3_req_dl ? ddr3_rd_dl : ddr3_rd_cas, ddr3_rd);
      end
   endtask

   // ==========================================================
   // Main sequence
   // ==========================================================

   initial begin
      errors      = 0;
      prop_errors = 0;
      checks      = 0;
      last_crop   = 0;
      lfsr_state  = 32'hae48_d39c;
      rst_n       = 1'b0;
      {status, img_mounted, img_size, hdmi_width, hdmi_height} = '0;
      {forced_scandoubler, ioctl_download, ioctl_index, board_reset} = '0;
      {fdc_enable, ocm_enable, rom_a_hide, rom_b_hide, sram_present} = '0;
      {tape_motor_on, cas_dout, adc_tape, adc_tape_act} = '0;
      {sd_spi_clk, sd_spi_mosi, sd_miso_pin, vsd_miso} = '0;
      {ddr3_addr_dl, ddr3_rd_dl, ddr3_req_dl, ddr3_addr_cas, ddr3_rd_cas} = '0;
      repeat (reset_cycles) @(posedge clock_bus);
      rst_n <= 1'b1;

      test_start = errors;
      resets_and_mask();
      report_test("resets and menu mask");
      test_start = errors;
      video_decode();
      report_test("video decode");
      test_start = errors;
      sd_routing();
      report_test("sd routing");
      test_start = errors;
      activity_light();
      report_test("activity light");
      test_start = errors;
      cassette_path();
      report_test("cassette path");
      test_start = errors;
      ddr3_sharing();
      report_test("ddr3 sharing");

      $display("%0d checks, %0d errors, %0d property errors", checks, errors, prop_errors);
      if (errors == 0 && prop_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* logic/shell_top.sv */
`timescale 1ns/1ps
`default_nettype none

module shell_top
   import shell_pkg::*;
#(
   parameter int act_timeout = 1000000
) (
   input  wire                      clock_bus,
   input  wire                      rst_n,

   // Host side
   input  wire [status_w-1:0]       status,
   input  wire [5:0]                img_mounted,
   input  wire [63:0]               img_size,
   input  wire [hdmi_dim_w-1:0]     hdmi_width,
   input  wire [hdmi_dim_w-1:0]     hdmi_height,
   input  wire                      forced_scandoubler,
   input  wire                      ioctl_download,
   input  wire [ioctl_index_w-1:0]  ioctl_index,

   // Device enables from the core
   input  wire                      fdc_enable,
   input  wire                      ocm_enable,
   input  wire                      rom_a_hide,
   input  wire                      rom_b_hide,
   input  wire                      sram_present,

   input  wire                      board_reset,

   // Tape
   input  wire                      tape_motor_on,
   input  wire                      cas_dout,
   input  wire                      adc_tape,
   input  wire                      adc_tape_act,

   // SD card
   input  wire                      sd_spi_clk,
   input  wire                      sd_spi_mosi,
   input  wire                      sd_miso_pin,
   input  wire                      vsd_miso,

   // DDR3 read requesters
   input  ddr3_addr_t               ddr3_addr_dl,
   input  wire                      ddr3_rd_dl,
   input  wire                      ddr3_req_dl,
   input  ddr3_addr_t               ddr3_addr_cas,
   input  wire                      ddr3_rd_cas,

   output logic                     core_reset,
   output logic                     hard_reset,
   output logic [15:0]              menu_mask,
   output logic [11:0]              video_arx,
   output logic [11:0]              video_ary,
   output logic [1:0]               vga_sl,
   output logic                     scandoubler,
   output logic                     hq2x,
   output logic [11:0]              crop_size,
   output logic                     sd_cs,
   output logic                     sd_sck,
   output logic                     sd_mosi,
   output logic                     sd_miso,
   output logic                     led_user,
   output logic [1:0]               led_disk,
   output logic                     tape_in,
   output logic                     tape_play,
   output logic                     tape_rewind,
   output ddr3_addr_t               ddr3_addr,
   output logic                     ddr3_rd
);

   wire img_size_nonzero = |img_size;

   status_decode u_status_decode (
      .clock_bus          (clock_bus),
      .rst_n              (rst_n),
      .board_reset        (board_reset),
      .status             (status),
      .img_mounted_vsd    (img_mounted[vsd_slot]),
      .fdc_enable         (fdc_enable),
      .ocm_enable         (ocm_enable),
      .rom_a_hide         (rom_a_hide),
      .rom_b_hide         (rom_b_hide),
      .sram_present       (sram_present),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .hard_reset         (hard_reset),
      .core_reset         (core_reset),
      .menu_mask          (menu_mask),
      .video_arx          (video_arx),
      .video_ary          (video_ary),
      .vga_sl             (vga_sl),
      .scandoubler        (scandoubler),
      .hq2x               (hq2x),
      .crop_size          (crop_size)
   );

   sd_router #(
      .act_timeout (act_timeout)
   ) u_sd_router (
      .clock_bus        (clock_bus),
      .rst_n            (rst_n),
      .img_mount_pulse  (img_mounted[vsd_slot]),
      .img_size_nonzero (img_size_nonzero),
      .sd_spi_clk       (sd_spi_clk),
      .sd_spi_mosi      (sd_spi_mosi),
      .sd_miso_pin      (sd_miso_pin),
      .vsd_miso         (vsd_miso),
      .sd_cs            (sd_cs),
      .sd_sck           (sd_sck),
      .sd_mosi          (sd_mosi),
      .sd_miso          (sd_miso),
      .led_user         (led_user),
      .led_disk         (led_disk)
   );

   // Core reset is the third rewind source
   tape_path u_tape_path (
      .clock_bus       (clock_bus),
      .rst_n           (rst_n),
      .ioctl_download  (ioctl_download),
      .ioctl_index     (ioctl_index),
      .status_rewind   (status[st_tape_rewind]),
      .status_tape_src (tape_src_t'(status[st_tape_src])),
      .core_reset      (core_reset),
      .tape_motor_on   (tape_motor_on),
      .cas_dout        (cas_dout),
      .adc_tape        (adc_tape),
      .adc_tape_act    (adc_tape_act),
      .ddr3_addr_dl    (ddr3_addr_dl),
      .ddr3_rd_dl      (ddr3_rd_dl),
      .ddr3_req_dl     (ddr3_req_dl),
      .ddr3_addr_cas   (ddr3_addr_cas),
      .ddr3_rd_cas     (ddr3_rd_cas),
      .tape_in         (tape_in),
      .tape_play       (tape_play),
      .tape_rewind     (tape_rewind),
      .ddr3_addr       (ddr3_addr),
      .ddr3_rd         (ddr3_rd)
   );

endmodule

`default_nettype wire

/* logic/tape_path.sv */
`timescale 1ns/1ps
`default_nettype none

module tape_path
   import shell_pkg::*;
(
   input  wire                      clock_bus,
   input  wire                      rst_n,
   input  wire                      ioctl_download,
   input  wire [ioctl_index_w-1:0]  ioctl_index,
   input  wire                      status_rewind,
   input  tape_src_t                status_tape_src,
   input  wire                      core_reset,
   input  wire                      tape_motor_on,
   input  wire                      cas_dout,
   input  wire                      adc_tape,
   input  wire                      adc_tape_act,
   input  ddr3_addr_t               ddr3_addr_dl,
   input  wire                      ddr3_rd_dl,
   input  wire                      ddr3_req_dl,
   input  ddr3_addr_t               ddr3_addr_cas,
   input  wire                      ddr3_rd_cas,
   output logic                     tape_in,
   output logic                     tape_play,
   output logic                     tape_rewind,
   output ddr3_addr_t               ddr3_addr,
   output logic                     ddr3_rd
);

   logic cas_dl;
   logic cas_dl_q;
   logic cas_load;

   // ==========================================================
   // Cassette image tracking
   // ==========================================================

   assign cas_dl = ioctl_download & (ioctl_index[5:0] == 6'(cas_index));

   // Sticky once a cassette image has fully arrived
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         cas_dl_q <= 1'b0;
         cas_load <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q && !cas_dl) begin
            cas_load <= 1'b1;
         end
      end
   end

   // Motor line is active low on the cassette port
   assign tape_play   = ~tape_motor_on & cas_load;

   // Rewind while a new image loads or the core restarts
   assign tape_rewind = status_rewind | cas_dl | core_reset;

   // ==========================================================
   // Tape input source
   // ==========================================================

   always_comb begin
      if (status_tape_src == tape_src_file) begin
         tape_in = cas_dout;
      end else begin
         tape_in = adc_tape & adc_tape_act;
      end
   end

   // ==========================================================
   // DDR3 read port
   // ==========================================================

   // ROM download owns the port whenever it asks for it
   assign ddr3_addr = ddr3_req_dl ? ddr3_addr_dl : ddr3_addr_cas;
   assign ddr3_rd   = ddr3_req_dl ? ddr3_rd_dl : ddr3_rd_cas;

endmodule

`default_nettype wire

/* logic/sd_router.sv */
`timescale 1ns/1ps
`default_nettype none

module sd_router #(
   parameter int act_timeout = 1000000
) (
   input  wire         clock_bus,
   input  wire         rst_n,
   input  wire         img_mount_pulse,
   input  wire         img_size_nonzero,
   input  wire         sd_spi_clk,
   input  wire         sd_spi_mosi,
   input  wire         sd_miso_pin,
   input  wire         vsd_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        sd_miso,
   output logic        led_user,
   output logic [1:0]  led_disk
);

   localparam int cnt_w = $clog2(act_timeout + 1);
   localparam logic [cnt_w-1:0] act_max = cnt_w'(act_timeout);

   logic             vsd_sel;
   logic             old_mosi;
   logic             old_miso;
   logic             spi_change;
   logic [cnt_w-1:0] quiet_cnt;
   logic             sd_act;

   // ==========================================================
   // Card selection
   // ==========================================================

   // Mounting an empty image hands the bus back to the physical card
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mount_pulse) begin
         vsd_sel <= img_size_nonzero;
      end
   end

   assign sd_cs   = vsd_sel;
   assign sd_sck  = sd_spi_clk & ~vsd_sel;
   assign sd_mosi = sd_spi_mosi & ~vsd_sel;
   assign sd_miso = vsd_sel ? vsd_miso : sd_miso_pin;

   // ==========================================================
   // Disk activity light
   // ==========================================================

   assign spi_change = (old_mosi ^ sd_spi_mosi) | (old_miso ^ sd_miso);

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         old_mosi  <= 1'b0;
         old_miso  <= 1'b0;
         quiet_cnt <= act_max;
         sd_act    <= 1'b0;
      end else begin
         old_mosi <= sd_spi_mosi;
         old_miso <= sd_miso;
         sd_act   <= spi_change | (quiet_cnt < act_max);
         if (spi_change) begin
            quiet_cnt <= '0;
         end else if (quiet_cnt < act_max) begin
            quiet_cnt <= quiet_cnt + 1'b1;
         end
      end
   end

   // Bit 1 set gives the core sole control of the disk LED
   assign led_user = sd_act & vsd_sel;
   assign led_disk = {1'b1, sd_act & ~vsd_sel};

endmodule

`default_nettype wire

/* logic/status_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module status_decode
   import shell_pkg::*;
(
   input  wire                   clock_bus,
   input  wire                   rst_n,
   input  wire                   board_reset,
   input  wire [status_w-1:0]    status,
   input  wire                   img_mounted_vsd,
   input  wire                   fdc_enable,
   input  wire                   ocm_enable,
   input  wire                   rom_a_hide,
   input  wire                   rom_b_hide,
   input  wire                   sram_present,
   input  wire                   forced_scandoubler,
   input  wire [hdmi_dim_w-1:0]  hdmi_width,
   input  wire [hdmi_dim_w-1:0]  hdmi_height,
   output logic                  hard_reset,
   output logic                  core_reset,
   output logic [15:0]           menu_mask,
   output logic [11:0]           video_arx,
   output logic [11:0]           video_ary,
   output logic [1:0]            vga_sl,
   output logic                  scandoubler,
   output logic                  hq2x,
   output logic [11:0]           crop_size
);

   localparam int scale_w = st_scale_hi - st_scale_lo;

   logic [1:0]         aspect;
   logic [scale_w-1:0] scale;
   logic [scale_w-1:0] sl_full;
   logic               mode_1080;

   // ==========================================================
   // Resets
   // ==========================================================

   assign hard_reset = board_reset | status[st_reset];

   // Reset after mount only applies with the floppy controller present
   assign core_reset = hard_reset
                     | status[st_detach]
                     | status[st_reset_close]
                     | (status[st_reset_mount] & img_mounted_vsd & fdc_enable);

   // ==========================================================
   // Option menu mask
   // ==========================================================

   always_comb begin
      menu_mask    = '0;
      menu_mask[0] = fdc_enable;
      menu_mask[1] = rom_a_hide | ocm_enable;
      menu_mask[2] = rom_b_hide | ocm_enable;
      menu_mask[3] = ocm_enable;
      // SRAM save/load entries hidden without backed RAM
      menu_mask[6] = ~sram_present;
      menu_mask[7] = tape_src_t'(status[st_tape_src]) == tape_src_adc;
   end

   // ==========================================================
   // Video settings
   // ==========================================================

   assign aspect = status[st_aspect_lo+1:st_aspect_lo];
   assign scale  = status[st_scale_hi-1:st_scale_lo];

   // Original aspect is 4:3, other settings select a scaler ARC preset
   assign video_arx = (aspect == 2'd0) ? 12'd4 : {10'd0, aspect - 2'd1};
   assign video_ary = (aspect == 2'd0) ? 12'd3 : 12'd0;

   assign sl_full     = (scale != '0) ? scale - 1'b1 : '0;
   assign vga_sl      = sl_full[1:0];
   assign scandoubler = forced_scandoubler | (scale != '0);
   assign hq2x        = scale == scale_w'(1);

   assign mode_1080 = (hdmi_width == hdmi_dim_w'(hdmi_1080_width))
                    & (hdmi_height == hdmi_dim_w'(hdmi_1080_height));

   // 216p crop on a 1080p output with the native line rate
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         crop_size <= '0;
      end else if (mode_1080 && !scandoubler) begin
         crop_size <= 12'(crop_1080);
      end else begin
         crop_size <= '0;
      end
   end

endmodule

`default_nettype wire

/* logic/shell_pkg.sv */
`default_nettype none

package shell_pkg;

   // ==========================================================
   // Host status word layout
   // ==========================================================

   localparam int status_w = 64;

   localparam int st_reset       = 0;
   // Two-bit aspect ratio
   localparam int st_aspect_lo   = 1;
   // Scandoubler effect occupies [st_scale_hi-1:st_scale_lo]
   localparam int st_scale_lo    = 3;
   localparam int st_scale_hi    = 6;
   localparam int st_tape_rewind = 9;
   localparam int st_detach      = 10;
   localparam int st_reset_mount = 12;
   localparam int st_reset_close = 21;
   localparam int st_tape_src    = 40;

   // ==========================================================
   // Download and memory widths
   // ==========================================================

   localparam int ddr3_addr_w = 28;
   typedef logic [ddr3_addr_w-1:0] ddr3_addr_t;

   localparam int ioctl_index_w = 16;
   // Cassette image index in the low six bits
   localparam int cas_index     = 5;

   // Mount slot of the virtual SD card image
   localparam int vsd_slot = 4;

   // ==========================================================
   // HDMI output and crop
   // ==========================================================

   localparam int hdmi_dim_w       = 12;
   localparam int hdmi_1080_width  = 1920;
   localparam int hdmi_1080_height = 1080;
   localparam int crop_1080        = 216;

   // Tape input source in status bit 40
   typedef enum logic {
      tape_src_file = 1'b0,
      tape_src_adc  = 1'b1
   } tape_src_t;

endpackage

`default_nettype wire
